// File: filelist.f
+incdir+tests
verilog/rv32_isa_pkg.sv
verilog/pipe_ctrl_pkg.sv
verilog/rv32_decoder.sv
verilog/dx_stage_ctrl.sv
verilog/wb_stage_ctrl.sv
verilog/pipe_ctrl_top.sv
tests/pipe_ctrl_tb.sv

// File: run_sim.sh
#!/bin/sh
# build and run the pipeline control testbench with verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f filelist.f --top-module pipe_ctrl_tb \
   -o pipe_ctrl_sim > build.log 2>&1
if [ $? -ne 0 ]; then
   echo "verilator build failed, see build.log"
   exit 1
fi

./obj_dir/pipe_ctrl_sim > sim.log 2>&1
if [ $? -ne 0 ]; then
   echo "simulation exited with an error, see sim.log"
   exit 1
fi

if grep -q "^TEST PASS$" sim.log; then
   echo "simulation passed"
   exit 0
fi
echo "simulation failed, see sim.log"
exit 1

// File: tests/pipe_ctrl_model.svh
alu_op_e arith_ops [8] = '{ALU_ADD, ALU_SLL, ALU_SLT, ALU_SLTU, ALU_XOR, ALU_SRL, ALU_OR, ALU_AND};
alu_op_e cmp_ops [8] = '{ALU_SEQ, ALU_SNE, ALU_ADD, ALU_ADD, ALU_SLT, ALU_SGE, ALU_SLTU, ALU_SGEU};

exe_ctrl_t  p_exe;
pc_src_e    p_target, p_pc;
ecode_e     p_code_dx, p_code_wb, m_wb_code;
logic       p_wr, p_mem, p_store, p_src, p_rs1u, p_rs2u, p_jump, p_ex_dx;
logic       p_ex_wb, p_stall_wb, p_stall_dx, p_kill_dx, p_kill_if;
logic       p_byp1, p_byp2, p_wr_wb, p_retire;
logic [4:0] p_rd, m_wb_rd;
logic       m_replay, m_dx_killed, m_wb_wr, m_wb_src, m_wb_ex, m_wb_mem, m_wb_store, m_wb_killed;

function automatic void model_decode(input inst_t inst, input logic cmp);
   logic [2:0] f3;
   logic       ill;
   f3 = inst[14:12];
   p_exe = '{ALU_ADD, IMM_I, SRC_A_RS1, SRC_B_IMM};
   {p_wr, p_mem, p_store, p_src, p_rs2u, p_jump, p_ex_dx, ill} = '0;
   p_rs1u = 1'b1;
   p_target = PC_PLUS_FOUR;
   p_code_dx = ECODE_INST_ADDR_MISALIGNED;
   case (inst[6:0])
      OPC_OP, OPC_OP_IMM: begin
         p_exe.alu_op = arith_ops[f3];
         if (f3 == 3'd5 && inst[30]) p_exe.alu_op = ALU_SRA;
         if (f3 == 3'd0 && inst[30] && inst[5]) p_exe.alu_op = ALU_SUB; // bit 5 set only for OP
         if (inst[5]) p_exe.src_b_sel = SRC_B_RS2;
         p_rs2u = inst[5];
         p_wr = 1'b1;
      end
      OPC_LUI, OPC_AUIPC: begin
         p_exe.src_a_sel = inst[5] ? SRC_A_ZERO : SRC_A_PC;
         p_exe.imm_type = IMM_U;
         p_rs1u = 1'b0;
         p_wr = 1'b1;
      end
      OPC_JAL, OPC_JALR: begin
         p_exe.src_a_sel = SRC_A_PC;
         p_exe.src_b_sel = SRC_B_FOUR;
         p_rs1u = inst[3] == 1'b0; // jalr reads rs1
         p_wr = 1'b1;
         p_jump = 1'b1;
         p_target = inst[3] ? PC_JAL_TARGET : PC_JALR_TARGET;
         ill = !inst[3] && f3 != 3'd0;
      end
      OPC_BRANCH: begin
         p_exe.src_b_sel = SRC_B_RS2;
         p_exe.alu_op = cmp_ops[f3];
         p_rs2u = 1'b1;
         p_jump = cmp;
         p_target = PC_BRANCH_TARGET;
         ill = f3[2:1] == 2'b01;
      end
      OPC_LOAD: begin
         p_mem = 1'b1;
         p_wr = 1'b1;
         p_src = 1'b1;
      end
      OPC_STORE: begin
         p_exe.imm_type = IMM_S;
         p_mem = 1'b1;
         p_store = 1'b1;
         p_rs2u = 1'b1;
      end
      OPC_MISC_MEM: ill = !(f3 == 3'd0 && inst[31:28] == 4'd0 && inst[19:7] == 13'd0);
      OPC_SYSTEM: begin
         p_ex_dx = 1'b1;
         if (inst == 32'h0000_0073) p_code_dx = ECODE_ECALL_FROM_U;
         else if (inst == 32'h0010_0073) p_code_dx = ECODE_BREAKPOINT;
         else ill = 1'b1;
      end
      default: ill = 1'b1;
   endcase
   if (ill) begin
      p_ex_dx = 1'b1;
      p_code_dx = ECODE_ILLEGAL_INST;
   end
endfunction

// combinational outputs for this cycle from the registered model state
function automatic void predict(input inst_t inst, input logic cmp, input logic dwait,
                                input logic dbad);
   logic raw1, raw2, load_wb, kill_wb, redirect;
   model_decode(inst, cmp);
   p_rd = inst[11:7];
   p_ex_wb = m_wb_ex || dbad;
   p_stall_wb = dwait && m_wb_mem && !p_ex_wb;
   kill_wb = p_stall_wb || p_ex_wb;
   p_wr_wb = m_wb_wr && !kill_wb;
   p_retire = !(kill_wb || m_wb_killed);
   load_wb = m_wb_mem && !m_wb_store;
   raw1 = p_wr_wb && p_rs1u && inst[19:15] != 5'd0 && inst[19:15] == m_wb_rd;
   raw2 = p_wr_wb && p_rs2u && inst[24:20] != 5'd0 && inst[24:20] == m_wb_rd;
   p_byp1 = raw1 && !load_wb;
   p_byp2 = raw2 && !load_wb;
   p_stall_dx = p_stall_wb || (load_wb && (raw1 || raw2) && !(p_ex_dx || p_ex_wb));
   p_kill_dx = p_stall_dx || p_ex_dx || p_ex_wb;
   redirect = p_jump && !p_kill_dx;
   p_kill_if = p_stall_dx || p_ex_dx || p_ex_wb || redirect || m_replay;
   if (p_ex_wb) p_pc = PC_HANDLER;
   else if (m_replay || p_stall_dx) p_pc = PC_REPLAY; // fetch never waits here
   else if (redirect) p_pc = p_target;
   else p_pc = PC_PLUS_FOUR;
   p_code_wb = m_wb_code;
   if (!m_wb_ex && dbad) p_code_wb = m_wb_wr ? ECODE_LOAD_ADDR_MISALIGNED
                                              : ECODE_STORE_ADDR_MISALIGNED;
endfunction

// rising edge
function automatic void commit_model();
   m_replay = 1'b0;
   if (!p_stall_wb) begin
      m_wb_wr = p_wr && !p_kill_dx;
      m_wb_rd = p_rd;
      m_wb_src = p_src;
      m_wb_ex = p_ex_dx;
      m_wb_code = p_code_dx;
      m_wb_mem = p_mem && !p_kill_dx;
      m_wb_store = p_store && !p_kill_dx;
      m_wb_killed = m_dx_killed || p_kill_dx;
   end
   if (!p_stall_dx) m_dx_killed = p_kill_if;
endfunction

function automatic void model_reset();
   {m_wb_wr, m_wb_src, m_wb_ex, m_wb_mem, m_wb_store} = '0;
   m_wb_rd = 5'd0;
   m_wb_code = ECODE_INST_ADDR_MISALIGNED;
   m_replay = 1'b1;
   m_dx_killed = 1'b1;
   m_wb_killed = 1'b1;
endfunction

// File: tests/pipe_ctrl_tb.sv
`timescale 1ns/1ps

module pipe_ctrl_tb;
   import rv32_isa_pkg::*;
   import pipe_ctrl_pkg::*;

   localparam inst_t NOP = 32'h0000_0013;

   logic clk = 1'b0;
   logic reset, imem_wait, imem_badmem_e, dmem_wait, dmem_badmem_e, cmp_true;
   inst_t inst_dx;
   exe_ctrl_t exe_ctrl;
   dmem_req_t dmem_req;
   pc_src_e pc_src;
   logic bypass_rs1, bypass_rs2, stall_if, kill_if, stall_dx, kill_dx, stall_wb, kill_wb;
   logic wr_reg_wb, exception_wb, retire_wb;
   reg_addr_t reg_to_wr_wb;
   wb_src_e wb_src_sel_wb;
   ecode_e exception_code_wb;

   logic [15:0] lfsr = 16'd21;
   int errors = 0;
   int test_start = 0;
   int tests_run = 0;
   int tests_failed = 0;

   `include "pipe_ctrl_model.svh"

   pipe_ctrl_top dut_i (.*);

   always #50 clk = ~clk;

   function automatic logic [31:0] rand_bits(input int n);
      logic [31:0] r;
      r = '0;
      for (int i = 0; i < n; i++) begin
         lfsr = {lfsr[14:0], lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10]};
         r = {r[30:0], lfsr[0]};
      end
      return r;
   endfunction

   task automatic check(input string name, input logic [31:0] exp, input logic [31:0] act);
      if (exp !== act) begin
         $display("ERR %s: expected %h, got %h", name, exp, act);
         errors++;
      end
   endtask

   task automatic check_all(input string name);
      check({name, ".pc_src"}, 32'(p_pc), 32'(pc_src));
      check({name, ".bypass_rs1"}, 32'(p_byp1), 32'(bypass_rs1));
      check({name, ".bypass_rs2"}, 32'(p_byp2), 32'(bypass_rs2));
      check({name, ".stall_if"}, 32'(p_stall_dx), 32'(stall_if));
      check({name, ".kill_if"}, 32'(p_kill_if), 32'(kill_if));
      check({name, ".stall_dx"}, 32'(p_stall_dx), 32'(stall_dx));
      check({name, ".kill_dx"}, 32'(p_kill_dx), 32'(kill_dx));
      check({name, ".stall_wb"}, 32'(p_stall_wb), 32'(stall_wb));
      check({name, ".kill_wb"}, 32'(p_stall_wb || p_ex_wb), 32'(kill_wb));
      check({name, ".dmem_en"}, 32'(p_mem && !p_kill_dx), 32'(dmem_req.en));
      check({name, ".dmem_wen"}, 32'(p_store && !p_kill_dx), 32'(dmem_req.wen));
      check({name, ".exception_wb"}, 32'(p_ex_wb), 32'(exception_wb));
      check({name, ".wr_reg_wb"}, 32'(p_wr_wb), 32'(wr_reg_wb));
      check({name, ".retire_wb"}, 32'(p_retire), 32'(retire_wb));
      if (p_wr_wb) begin
         check({name, ".reg_to_wr_wb"}, 32'(m_wb_rd), 32'(reg_to_wr_wb));
         check({name, ".wb_src_sel_wb"}, 32'(m_wb_src), 32'(wb_src_sel_wb));
      end
      if (p_ex_wb) check({name, ".exception_code_wb"}, 32'(p_code_wb), 32'(exception_code_wb));
   endtask

   // one clock: drive on the falling edge, outputs settle before the check
   task automatic cycle(input inst_t inst, input logic cmp, input logic dwait, input logic dbad);
      @(negedge clk);
      commit_model();
      inst_dx = inst;
      cmp_true = cmp;
      dmem_wait = dwait;
      dmem_badmem_e = dbad;
      predict(inst, cmp, dwait, dbad);
      #1;
   endtask

   task automatic apply_reset();
      reset = 1'b1;
      repeat (16) @(posedge clk);
      @(negedge clk);
      reset = 1'b0;
      model_reset();
      predict(NOP, 1'b0, 1'b0, 1'b0);
      #1;
   endtask

   task automatic finish_test(input string name);
      tests_run++;
      if (errors == test_start) begin
         $display("test %s: ok", name);
      end else begin
         $display("test %s: %0d errors", name, errors - test_start);
         tests_failed++;
      end
      test_start = errors;
   endtask

   // hold the same word in dx while it is stalled
   task automatic wait_stall_dx(input string name, input inst_t inst, input int limit);
      int n;
      n = 0;
      while (stall_dx && n < limit) begin
         cycle(inst, 1'b0, 1'b0, 1'b0);
         check_all(name);
         n++;
      end
      if (stall_dx) begin
         $display("%s: timeout, stall_dx still high after %0d cycles", name, limit);
         errors++;
      end
   endtask

   initial begin
      inst_t inst;
      inst_t exc [3];
      ecode_e exc_code [3];
      logic [31:0] w;
      logic [4:0] rd;
      int n;
      reset = 1'b1;
      inst_dx = NOP;
      {imem_wait, imem_badmem_e, dmem_wait, dmem_badmem_e, cmp_true} = '0;
      apply_reset();
      check("reset.retire_wb", 32'd0, 32'(retire_wb));
      check("reset.wr_reg_wb", 32'd0, 32'(wr_reg_wb));
      check("reset.exception_wb", 32'd0, 32'(exception_wb));
      check("reset.pc_src", 32'(PC_REPLAY), 32'(pc_src));
      finish_test("reset");

      for (int i = 0; i < 60; i++) begin
         inst = rand_bits(32);
         w = rand_bits(3) % 6;
         case (w)
            0: inst[6:0] = OPC_OP;
            1: inst[6:0] = OPC_OP_IMM;
            2: inst[6:0] = OPC_LUI;
            3: inst[6:0] = OPC_AUIPC;
            4: inst[6:0] = OPC_JAL;
            default: inst[6:0] = OPC_JALR;
         endcase
         if (inst[6:0] == OPC_JALR) inst[14:12] = 3'd0;
         cycle(inst, 1'b0, 1'b0, 1'b0);
         check("alu.exe_ctrl", 32'(p_exe), 32'(exe_ctrl));
         check_all("alu");
      end
      finish_test("alu_decode");

      for (int i = 0; i < 40; i++) begin
         inst = rand_bits(32);
         inst[6:0] = OPC_BRANCH;
         if (inst[14:13] == 2'b01) inst[14] = 1'b1;
         w = rand_bits(1);
         cycle(inst, w[0], 1'b0, 1'b0);
         check("branch.exe_ctrl", 32'(p_exe), 32'(exe_ctrl));
         check_all("branch");
         if (pc_src == PC_BRANCH_TARGET) check("branch.kill_if", 32'd1, 32'(kill_if));
      end
      finish_test("branch");

      for (int i = 0; i < 6; i++) begin
         w = rand_bits(32);
         rd = (w[4:0] == 5'd0) ? 5'd1 : w[4:0];
         cycle({12'd0, 5'd2, 3'b010, rd, OPC_LOAD}, 1'b0, 1'b0, 1'b0);
         check_all("load_use");
         inst = {7'd0, 5'd3, rd, 3'b000, 5'd4, OPC_OP};
         cycle(inst, 1'b0, 1'b0, 1'b0);
         check_all("load_use");
         check("load_use.stall_dx", 32'd1, 32'(stall_dx));
         wait_stall_dx("load_use", inst, 8);
         cycle({12'd5, 5'd2, 3'b000, rd, OPC_OP_IMM}, 1'b0, 1'b0, 1'b0);
         cycle({7'd0, rd, 5'd3, 3'b000, 5'd4, OPC_OP}, 1'b0, 1'b0, 1'b0);
         check_all("bypass");
         check("bypass.bypass_rs2", 32'd1, 32'(bypass_rs2));
         check("bypass.stall_dx", 32'd0, 32'(stall_dx));
         cycle({12'd0, 5'd2, 3'b010, 5'd0, OPC_LOAD}, 1'b0, 1'b0, 1'b0);
         cycle({7'd0, 5'd0, 5'd0, 3'b000, 5'd4, OPC_OP}, 1'b0, 1'b0, 1'b0);
         check_all("x0");
         check("x0.stall_dx", 32'd0, 32'(stall_dx));
         check("x0.bypass_rs1", 32'd0, 32'(bypass_rs1));
      end
      finish_test("hazard");

      exc[0] = rand_bits(32);
      exc[0][6:0] = 7'b1111111; // no such major opcode
      exc[1] = 32'h0000_0073;
      exc[2] = 32'h0010_0073;
      exc_code[0] = ECODE_ILLEGAL_INST;
      exc_code[1] = ECODE_ECALL_FROM_U;
      exc_code[2] = ECODE_BREAKPOINT;
      for (int i = 0; i < 3; i++) begin
         cycle(exc[i], 1'b0, 1'b0, 1'b0);
         check_all("exception");
         cycle(NOP, 1'b0, 1'b0, 1'b0);
         check_all("exception");
         check("exception.exception_wb", 32'd1, 32'(exception_wb));
         check("exception.code", 32'(exc_code[i]), 32'(exception_code_wb));
         check("exception.pc_src", 32'(PC_HANDLER), 32'(pc_src));
         check("exception.wr_reg_wb", 32'd0, 32'(wr_reg_wb));
      end
      cycle({12'd0, 5'd2, 3'b010, 5'd7, OPC_LOAD}, 1'b0, 1'b0, 1'b0);
      cycle(NOP, 1'b0, 1'b0, 1'b1);
      check_all("misaligned_load");
      check("misaligned_load.code", 32'(ECODE_LOAD_ADDR_MISALIGNED), 32'(exception_code_wb));
      cycle({7'd0, 5'd5, 5'd2, 3'b010, 5'd0, OPC_STORE}, 1'b0, 1'b0, 1'b0);
      cycle(NOP, 1'b0, 1'b0, 1'b1);
      check_all("misaligned_store");
      check("misaligned_store.code", 32'(ECODE_STORE_ADDR_MISALIGNED), 32'(exception_code_wb));
      finish_test("exception");

      for (int i = 0; i < 6; i++) begin
         w = rand_bits(32);
         rd = w[4:0];
         cycle({12'd0, 5'd2, 3'b010, rd, OPC_LOAD}, 1'b0, 1'b0, 1'b0);
         n = 0;
         w = 32'd1;
         // max run of ones from a 16 bit lfsr is 16
         while (w[0] && n < 32) begin
            w = rand_bits(1);
            cycle(NOP, 1'b0, w[0], 1'b0);
            check_all("dmem_wait");
            if (w[0]) begin
               check("dmem_wait.stall_wb", 32'd1, 32'(stall_wb));
               check("dmem_wait.stall_dx", 32'd1, 32'(stall_dx));
               check("dmem_wait.stall_if", 32'd1, 32'(stall_if));
               check("dmem_wait.reg_to_wr_wb", 32'(rd), 32'(reg_to_wr_wb));
               check("dmem_wait.wb_src_sel_wb", 32'(WB_SRC_MEM), 32'(wb_src_sel_wb));
            end
            n++;
         end
         if (w[0]) begin
            $display("dmem_wait: timeout, wait never dropped within 32 cycles");
            errors++;
         end
      end
      finish_test("dmem_wait");

      $display("%0d tests run, %0d failed, %0d errors", tests_run, tests_failed, errors);
      if (errors == 0) begin
         $display("TEST PASS");
      end else begin
         $display("TEST FAIL");
      end
      $finish;
   end

endmodule

// File: verilog/dx_stage_ctrl.sv
`timescale 1ns/1ps

module dx_stage_ctrl (
   input  logic                      clk,
   input  logic                      reset,
   input  logic                      imem_wait,
   input  logic                      imem_badmem_e,
   input  rv32_isa_pkg::inst_t       inst_dx,
   input  pipe_ctrl_pkg::dec_t       dec,
   input  logic                      stall_wb,
   input  logic                      ex_wb,
   input  logic                      wr_reg_wb,
   input  logic                      load_in_wb,
   input  rv32_isa_pkg::reg_addr_t   reg_to_wr_wb,
   output pipe_ctrl_pkg::exe_ctrl_t  exe_ctrl,
   output pipe_ctrl_pkg::dmem_req_t  dmem_req,
   output pipe_ctrl_pkg::pc_src_e    pc_src,
   output logic                      bypass_rs1,
   output logic                      bypass_rs2,
   output logic                      stall_if,
   output logic                      kill_if,
   output logic                      stall_dx,
   output logic                      kill_dx,
   output logic                      ex_dx,
   output rv32_isa_pkg::ecode_e      ex_code_dx,
   output pipe_ctrl_pkg::wb_state_t  wb_next
);
   import rv32_isa_pkg::*;
   import pipe_ctrl_pkg::*;

   logic      replay_if;
   logic      had_ex_dx;
   logic      prev_killed_dx;
   logic      ex_if;
   logic      branch_taken, jal, jalr, redirect;
   logic      raw_rs1, raw_rs2, load_use;
   reg_addr_t rs1_addr, rs2_addr;

   assign rs1_addr = inst_dx[19:15];
   assign rs2_addr = inst_dx[24:20];

   always_ff @(posedge clk) begin
      if (reset) begin
         replay_if <= 1'b1;
         had_ex_dx <= 1'b0;
         prev_killed_dx <= 1'b1; // dx holds a bubble after reset
      end else begin
         replay_if <= redirect && imem_wait; // target fetch was lost
         if (!stall_dx) begin
            had_ex_dx <= ex_if;
            prev_killed_dx <= kill_if;
         end
      end
   end

   assign ex_if = imem_badmem_e && !imem_wait && !redirect && !replay_if;
   assign kill_if = stall_if || ex_if || ex_dx || ex_wb || redirect || replay_if;
   assign stall_if = stall_dx || (imem_wait && !redirect && !ex_wb);

   assign ex_dx = had_ex_dx || dec.illegal || dec.ebreak || dec.ecall;
   assign kill_dx = stall_dx || ex_dx || ex_wb;
   assign stall_dx = stall_wb || (load_use && !(ex_dx || ex_wb));

   always_comb begin
      if (had_ex_dx) ex_code_dx = ECODE_INST_ADDR_MISALIGNED;
      else if (dec.illegal) ex_code_dx = ECODE_ILLEGAL_INST;
      else if (dec.ebreak) ex_code_dx = ECODE_BREAKPOINT;
      else if (dec.ecall) ex_code_dx = ECODE_ECALL_FROM_U;
      else ex_code_dx = ECODE_INST_ADDR_MISALIGNED;
   end

   assign branch_taken = dec.branch && !kill_dx;
   assign jal = dec.jal && !kill_dx;
   assign jalr = dec.jalr && !kill_dx;
   assign redirect = branch_taken || jal || jalr;

   always_comb begin
      if (ex_wb) pc_src = PC_HANDLER;
      else if (replay_if || (stall_if && !imem_wait)) pc_src = PC_REPLAY;
      else if (branch_taken) pc_src = PC_BRANCH_TARGET;
      else if (jal) pc_src = PC_JAL_TARGET;
      else if (jalr) pc_src = PC_JALR_TARGET;
      else pc_src = PC_PLUS_FOUR;
   end

   assign exe_ctrl = dec.exe_ctrl;

   always_comb begin
      dmem_req = dec.dmem_req;
      dmem_req.en = dec.dmem_req.en && !kill_dx;
      dmem_req.wen = dec.dmem_req.wen && !kill_dx;
   end

   // raw against wb, x0 never forwarded
   assign raw_rs1 = wr_reg_wb && dec.uses_rs1 && rs1_addr != '0 && rs1_addr == reg_to_wr_wb;
   assign raw_rs2 = wr_reg_wb && dec.uses_rs2 && rs2_addr != '0 && rs2_addr == reg_to_wr_wb;
   assign bypass_rs1 = raw_rs1 && !load_in_wb;
   assign bypass_rs2 = raw_rs2 && !load_in_wb;
   assign load_use = load_in_wb && (raw_rs1 || raw_rs2);

   always_comb begin
      wb_next.wr_reg_unkilled = dec.wr_reg && !kill_dx;
      wb_next.reg_to_wr = inst_dx[11:7];
      wb_next.wb_src = dec.wb_src;
      wb_next.had_ex = ex_dx;
      wb_next.prev_ex_code = ex_code_dx;
      wb_next.dmem_en = dmem_req.en;
      wb_next.store = dmem_req.wen;
      wb_next.prev_killed = prev_killed_dx || kill_dx;
   end

endmodule

// File: verilog/pipe_ctrl_pkg.sv
package pipe_ctrl_pkg;

   typedef enum logic [3:0] {
      ALU_ADD  = 4'd0,
      ALU_SLL  = 4'd1,
      ALU_XOR  = 4'd4,
      ALU_SRL  = 4'd5,
      ALU_OR   = 4'd6,
      ALU_AND  = 4'd7,
      ALU_SEQ  = 4'd8,
      ALU_SNE  = 4'd9,
      ALU_SUB  = 4'd10,
      ALU_SRA  = 4'd11,
      ALU_SLT  = 4'd12,
      ALU_SGE  = 4'd13,
      ALU_SLTU = 4'd14,
      ALU_SGEU = 4'd15
   } alu_op_e;

   typedef enum logic [1:0] {IMM_I, IMM_S, IMM_U} imm_type_e;
   typedef enum logic [1:0] {SRC_A_RS1, SRC_A_PC, SRC_A_ZERO} src_a_sel_e;
   typedef enum logic [1:0] {SRC_B_RS2, SRC_B_IMM, SRC_B_FOUR} src_b_sel_e;
   typedef enum logic {WB_SRC_ALU, WB_SRC_MEM} wb_src_e;

   typedef enum logic [2:0] {
      PC_PLUS_FOUR, PC_BRANCH_TARGET, PC_JAL_TARGET, PC_JALR_TARGET, PC_REPLAY, PC_HANDLER
   } pc_src_e;

   typedef struct packed {
      logic       en;
      logic       wen;
      logic [2:0] size;
      logic [2:0] mem_type; // funct3 as given, sign info in bit 2
   } dmem_req_t;

   typedef struct packed {
      alu_op_e    alu_op;
      imm_type_e  imm_type;
      src_a_sel_e src_a_sel;
      src_b_sel_e src_b_sel;
   } exe_ctrl_t;

   typedef struct packed {
      exe_ctrl_t exe_ctrl;
      dmem_req_t dmem_req;
      logic      wr_reg;
      wb_src_e   wb_src;
      logic      uses_rs1;
      logic      uses_rs2;
      logic      branch;  // branch taken
      logic      jal;
      logic      jalr;
      logic      illegal;
      logic      ecall;
      logic      ebreak;
   } dec_t;

   typedef struct packed {
      logic                  wr_reg_unkilled;
      rv32_isa_pkg::reg_addr_t reg_to_wr;
      wb_src_e               wb_src;
      logic                  had_ex;
      rv32_isa_pkg::ecode_e  prev_ex_code;
      logic                  dmem_en;
      logic                  store;
      logic                  prev_killed;
   } wb_state_t;

endpackage

// File: verilog/pipe_ctrl_top.sv
`timescale 1ns/1ps

module pipe_ctrl_top (
   input  logic                     clk,
   input  logic                     reset,
   input  rv32_isa_pkg::inst_t      inst_dx,
   input  logic                     imem_wait,
   input  logic                     imem_badmem_e,
   input  logic                     dmem_wait,
   input  logic                     dmem_badmem_e,
   input  logic                     cmp_true,
   output pipe_ctrl_pkg::exe_ctrl_t exe_ctrl,
   output pipe_ctrl_pkg::dmem_req_t dmem_req,
   output pipe_ctrl_pkg::pc_src_e   pc_src,
   output logic                     bypass_rs1,
   output logic                     bypass_rs2,
   output logic                     stall_if,
   output logic                     kill_if,
   output logic                     stall_dx,
   output logic                     kill_dx,
   output logic                     stall_wb,
   output logic                     kill_wb,
   output logic                     wr_reg_wb,
   output rv32_isa_pkg::reg_addr_t  reg_to_wr_wb,
   output pipe_ctrl_pkg::wb_src_e   wb_src_sel_wb,
   output logic                     exception_wb,
   output rv32_isa_pkg::ecode_e     exception_code_wb,
   output logic                     retire_wb
);
   import rv32_isa_pkg::*;
   import pipe_ctrl_pkg::*;

   dec_t      dec;
   wb_state_t wb_next;
   ecode_e    ex_code_dx;
   logic      ex_dx;
   logic      load_in_wb;

   rv32_decoder decoder_i (
      .inst_dx  (inst_dx),
      .cmp_true (cmp_true),
      .dec      (dec)
   );

   dx_stage_ctrl dx_ctrl_i (
      .clk           (clk),
      .reset         (reset),
      .imem_wait     (imem_wait),
      .imem_badmem_e (imem_badmem_e),
      .inst_dx       (inst_dx),
      .dec           (dec),
      .stall_wb      (stall_wb),
      .ex_wb         (exception_wb),
      .wr_reg_wb     (wr_reg_wb),
      .load_in_wb    (load_in_wb),
      .reg_to_wr_wb  (reg_to_wr_wb),
      .exe_ctrl      (exe_ctrl),
      .dmem_req      (dmem_req),
      .pc_src        (pc_src),
      .bypass_rs1    (bypass_rs1),
      .bypass_rs2    (bypass_rs2),
      .stall_if      (stall_if),
      .kill_if       (kill_if),
      .stall_dx      (stall_dx),
      .kill_dx       (kill_dx),
      .ex_dx         (ex_dx),
      .ex_code_dx    (ex_code_dx),
      .wb_next       (wb_next)
   );

   wb_stage_ctrl wb_ctrl_i (
      .clk               (clk),
      .reset             (reset),
      .dmem_wait         (dmem_wait),
      .dmem_badmem_e     (dmem_badmem_e),
      .ex_dx             (ex_dx),
      .ex_code_dx        (ex_code_dx),
      .wb_next           (wb_next),
      .stall_wb          (stall_wb),
      .kill_wb           (kill_wb),
      .ex_wb             (exception_wb),
      .wr_reg_wb         (wr_reg_wb),
      .load_in_wb        (load_in_wb),
      .retire_wb         (retire_wb),
      .reg_to_wr_wb      (reg_to_wr_wb),
      .wb_src_sel_wb     (wb_src_sel_wb),
      .exception_code_wb (exception_code_wb)
   );

endmodule

// File: verilog/rv32_decoder.sv
`timescale 1ns/1ps

module rv32_decoder (
   input  rv32_isa_pkg::inst_t inst_dx,
   input  logic                cmp_true,
   output pipe_ctrl_pkg::dec_t dec
);
   import rv32_isa_pkg::*;
   import pipe_ctrl_pkg::*;

   funct3_t     funct3;
   logic [6:0]  funct7;
   logic [11:0] funct12;
   reg_addr_t   rs1_addr;
   reg_addr_t   rd_addr;
   alu_op_e     alu_op_arith;

   assign funct3 = inst_dx[14:12];
   assign funct7 = inst_dx[31:25];
   assign funct12 = inst_dx[31:20];
   assign rs1_addr = inst_dx[19:15];
   assign rd_addr = inst_dx[11:7];

   always_comb begin
      case (funct3)
         F3_ADD_SUB: alu_op_arith = (inst_dx[6:0] == OPC_OP && funct7[5]) ? ALU_SUB : ALU_ADD;
         F3_SLL:     alu_op_arith = ALU_SLL;
         F3_SLT:     alu_op_arith = ALU_SLT;
         F3_SLTU:    alu_op_arith = ALU_SLTU;
         F3_XOR:     alu_op_arith = ALU_XOR;
         F3_SRL_SRA: alu_op_arith = funct7[5] ? ALU_SRA : ALU_SRL;
         F3_OR:      alu_op_arith = ALU_OR;
         default:    alu_op_arith = ALU_AND;
      endcase
   end

   always_comb begin
      dec = '0;
      dec.exe_ctrl.alu_op = ALU_ADD;
      dec.exe_ctrl.imm_type = IMM_I;
      dec.exe_ctrl.src_a_sel = SRC_A_RS1;
      dec.exe_ctrl.src_b_sel = SRC_B_IMM;
      dec.dmem_req.size = {1'b0, funct3[1:0]};
      dec.dmem_req.mem_type = funct3;
      dec.wb_src = WB_SRC_ALU;
      dec.uses_rs1 = 1'b1;
      case (opcode_e'(inst_dx[6:0]))
         OPC_LOAD: begin
            dec.dmem_req.en = 1'b1;
            dec.wr_reg = 1'b1;
            dec.wb_src = WB_SRC_MEM;
         end
         OPC_STORE: begin
            dec.uses_rs2 = 1'b1;
            dec.exe_ctrl.imm_type = IMM_S;
            dec.dmem_req.en = 1'b1;
            dec.dmem_req.wen = 1'b1;
         end
         OPC_BRANCH: begin
            dec.uses_rs2 = 1'b1;
            dec.branch = cmp_true;
            dec.exe_ctrl.src_b_sel = SRC_B_RS2;
            case (funct3)
               F3_BEQ:  dec.exe_ctrl.alu_op = ALU_SEQ;
               F3_BNE:  dec.exe_ctrl.alu_op = ALU_SNE;
               F3_BLT:  dec.exe_ctrl.alu_op = ALU_SLT;
               F3_BGE:  dec.exe_ctrl.alu_op = ALU_SGE;
               F3_BLTU: dec.exe_ctrl.alu_op = ALU_SLTU;
               F3_BGEU: dec.exe_ctrl.alu_op = ALU_SGEU;
               default: dec.illegal = 1'b1;
            endcase
         end
         OPC_JAL, OPC_JALR: begin
            // link value is pc + 4
            dec.jal = (inst_dx[6:0] == OPC_JAL);
            dec.jalr = (inst_dx[6:0] == OPC_JALR);
            dec.illegal = dec.jalr && (funct3 != 3'd0);
            dec.uses_rs1 = dec.jalr;
            dec.exe_ctrl.src_a_sel = SRC_A_PC;
            dec.exe_ctrl.src_b_sel = SRC_B_FOUR;
            dec.wr_reg = 1'b1;
         end
         OPC_MISC_MEM: begin
            // only plain fence, which needs no action
            dec.illegal = !(funct3 == F3_FENCE && inst_dx[31:28] == 4'd0 &&
                            rs1_addr == '0 && rd_addr == '0);
         end
         OPC_OP_IMM: begin
            dec.exe_ctrl.alu_op = alu_op_arith;
            dec.wr_reg = 1'b1;
         end
         OPC_OP: begin
            dec.uses_rs2 = 1'b1;
            dec.exe_ctrl.src_b_sel = SRC_B_RS2;
            dec.exe_ctrl.alu_op = alu_op_arith;
            dec.wr_reg = 1'b1;
         end
         OPC_AUIPC, OPC_LUI: begin
            dec.uses_rs1 = 1'b0;
            dec.exe_ctrl.src_a_sel = (inst_dx[6:0] == OPC_LUI) ? SRC_A_ZERO : SRC_A_PC;
            dec.exe_ctrl.imm_type = IMM_U;
            dec.wr_reg = 1'b1;
         end
         OPC_SYSTEM: begin
            if (funct3 == F3_PRIV && rs1_addr == '0 && rd_addr == '0 &&
                funct12 == F12_ECALL) dec.ecall = 1'b1;
            else if (funct3 == F3_PRIV && rs1_addr == '0 && rd_addr == '0 &&
                     funct12 == F12_EBREAK) dec.ebreak = 1'b1;
            else dec.illegal = 1'b1;
         end
         default: dec.illegal = 1'b1;
      endcase
   end

   always_comb begin
      assert (!dec.dmem_req.wen || dec.dmem_req.en)
         else $error("store decoded without memory enable");
   end

endmodule

// File: verilog/rv32_isa_pkg.sv
package rv32_isa_pkg;

   typedef logic [31:0] inst_t;
   typedef logic [4:0] reg_addr_t;
   typedef logic [2:0] funct3_t;

   // major opcodes, inst[6:0]
   typedef enum logic [6:0] {
      OPC_LOAD     = 7'b0000011,
      OPC_MISC_MEM = 7'b0001111,
      OPC_OP_IMM   = 7'b0010011,
      OPC_AUIPC    = 7'b0010111,
      OPC_STORE    = 7'b0100011,
      OPC_OP       = 7'b0110011,
      OPC_LUI      = 7'b0110111,
      OPC_BRANCH   = 7'b1100011,
      OPC_JALR     = 7'b1100111,
      OPC_JAL      = 7'b1101111,
      OPC_SYSTEM   = 7'b1110011
   } opcode_e;

   localparam funct3_t F3_BEQ = 3'd0;
   localparam funct3_t F3_BNE = 3'd1;
   localparam funct3_t F3_BLT = 3'd4;
   localparam funct3_t F3_BGE = 3'd5;
   localparam funct3_t F3_BLTU = 3'd6;
   localparam funct3_t F3_BGEU = 3'd7;

   localparam funct3_t F3_ADD_SUB = 3'd0;
   localparam funct3_t F3_SLL = 3'd1;
   localparam funct3_t F3_SLT = 3'd2;
   localparam funct3_t F3_SLTU = 3'd3;
   localparam funct3_t F3_XOR = 3'd4;
   localparam funct3_t F3_SRL_SRA = 3'd5;
   localparam funct3_t F3_OR = 3'd6;
   localparam funct3_t F3_AND = 3'd7;

   localparam funct3_t F3_FENCE = 3'd0;
   localparam funct3_t F3_PRIV = 3'd0;

   localparam logic [11:0] F12_ECALL = 12'h000;
   localparam logic [11:0] F12_EBREAK = 12'h001;

   typedef enum logic [3:0] {
      ECODE_INST_ADDR_MISALIGNED  = 4'd0,
      ECODE_ILLEGAL_INST          = 4'd2,
      ECODE_BREAKPOINT            = 4'd3,
      ECODE_LOAD_ADDR_MISALIGNED  = 4'd4,
      ECODE_STORE_ADDR_MISALIGNED = 4'd6,
      ECODE_ECALL_FROM_U          = 4'd8
   } ecode_e;

endpackage

// File: verilog/wb_stage_ctrl.sv
`timescale 1ns/1ps

module wb_stage_ctrl (
   input  logic                     clk,
   input  logic                     reset,
   input  logic                     dmem_wait,
   input  logic                     dmem_badmem_e,
   input  logic                     ex_dx,
   input  rv32_isa_pkg::ecode_e     ex_code_dx,
   input  pipe_ctrl_pkg::wb_state_t wb_next,
   output logic                     stall_wb,
   output logic                     kill_wb,
   output logic                     ex_wb,
   output logic                     wr_reg_wb,
   output logic                     load_in_wb,
   output logic                     retire_wb,
   output rv32_isa_pkg::reg_addr_t  reg_to_wr_wb,
   output pipe_ctrl_pkg::wb_src_e   wb_src_sel_wb,
   output rv32_isa_pkg::ecode_e     exception_code_wb
);
   import rv32_isa_pkg::*;
   import pipe_ctrl_pkg::*;

   wb_state_t wb_q;

   always_ff @(posedge clk) begin
      if (reset) begin
         wb_q.wr_reg_unkilled <= 1'b0;
         wb_q.had_ex <= 1'b0;
         wb_q.dmem_en <= 1'b0;
         wb_q.store <= 1'b0;
         wb_q.prev_killed <= 1'b1;
      end else if (!stall_wb) begin
         wb_q <= wb_next;
      end
   end

   assign ex_wb = wb_q.had_ex || dmem_badmem_e;
   assign stall_wb = dmem_wait && wb_q.dmem_en && !ex_wb;
   assign kill_wb = stall_wb || ex_wb;

   always_comb begin
      exception_code_wb = wb_q.prev_ex_code;
      if (!wb_q.had_ex && dmem_badmem_e) begin
         // a load writes rd, a store does not
         exception_code_wb = wb_q.wr_reg_unkilled ? ECODE_LOAD_ADDR_MISALIGNED
                                                  : ECODE_STORE_ADDR_MISALIGNED;
      end
   end

   assign wr_reg_wb = wb_q.wr_reg_unkilled && !kill_wb;
   assign retire_wb = !(kill_wb || wb_q.prev_killed);
   assign load_in_wb = wb_q.dmem_en && !wb_q.store;
   assign reg_to_wr_wb = wb_q.reg_to_wr;
   assign wb_src_sel_wb = wb_q.wb_src;

   assert property (@(posedge clk) disable iff (reset) !(wr_reg_wb && ex_wb))
      else $error("register write with exception in wb");

endmodule
